// ==== cheat_engine.sv ====
// Cheat table and registered bus read-data patcher,
// shared by the 68000 and Z80 buses through a payload type
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module cheat_engine #(
	parameter type data_t = logic [15:0],
	parameter int  ADDR_W = 24
) (
	input  logic                clk_sys,
	input  logic                sys_reset,
	input  logic                clear_i,
	input  md_pkg::cheat_code_t code_i,
	input  logic                code_valid_i,
	input  logic                enable_i,
	input  logic [ADDR_W-1:0]   bus_addr_i,
	input  data_t               bus_data_i,
	output data_t               bus_data_o,
	output logic                available_o
);

	localparam int SLOTS = `MD_CHEAT_SLOTS;
	localparam int DW    = $bits(data_t);
	localparam int CNT_W = $clog2(SLOTS + 1);
	localparam int IDX_W = $clog2(SLOTS);

	md_pkg::cheat_code_t slot_code [SLOTS];
	logic [CNT_W-1:0]    slot_cnt;
	logic [SLOTS-1:0]    slot_hit;
	data_t               patch_data;
	logic                table_full;

	assign table_full  = (slot_cnt == CNT_W'(SLOTS));
	assign available_o = (slot_cnt != '0);

	////////////////////
	// Code table

	// Slots fill from 0 upward, so the count alone says which are valid
	always_ff @(posedge clk_sys) begin
		if (sys_reset || clear_i) begin
			slot_cnt <= '0;
		end else if (code_valid_i && !table_full) begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!clear_i && code_valid_i && !table_full) begin
			slot_code[slot_cnt[IDX_W-1:0]] <= code_i;
		end
	end

	////////////////////
	// Match and replace

	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			slot_hit[i] = (CNT_W'(i) < slot_cnt) &&
				(slot_code[i].address[ADDR_W-1:0] == bus_addr_i) &&
				(!slot_code[i].flags[0] || slot_code[i].compare[DW-1:0] == bus_data_i);
		end
	end

	// Walk down so the lowest matching slot is the last to win
	always_comb begin
		patch_data = bus_data_i;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (slot_hit[i]) begin
				patch_data = data_t'(slot_code[i].replace[DW-1:0]);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			bus_data_o <= '0;
		end else if (enable_i) begin
			bus_data_o <= patch_data;
		end else begin
			bus_data_o <= bus_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== cheat_loader.sv ====
// Cheat code assembly from eight download words
// with a pulse once the last word is in
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module cheat_loader (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     wr_i,
	input  logic [`MD_DL_ADDR_W-1:0] addr_i,
	input  logic [`MD_DL_DATA_W-1:0] data_i,
	input  md_pkg::dl_kind_t         kind_i,
	output md_pkg::cheat_code_t      code_o,
	output logic                     code_valid_o
);

	// Byte address of the final word of a code
	localparam logic [3:0] LAST_WORD = 4'((`MD_CODE_WORDS - 1) * 2);

	logic code_wr;

	assign code_wr = wr_i & (kind_i == md_pkg::DL_CHEAT);

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			code_valid_o <= 1'b0;
		end else begin
			code_valid_o <= code_wr & (addr_i[3:0] == LAST_WORD);
		end
	end

	// Low word first in each 32-bit field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (addr_i[3:0])
				4'd0:  code_o.flags[15:0]    <= data_i;
				4'd2:  code_o.flags[31:16]   <= data_i;
				4'd4:  code_o.address[15:0]  <= data_i;
				4'd6:  code_o.address[31:16] <= data_i;
				4'd8:  code_o.compare[15:0]  <= data_i;
				4'd10: code_o.compare[31:16] <= data_i;
				4'd12: code_o.replace[15:0]  <= data_i;
				4'd14: code_o.replace[31:16] <= data_i;
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== dl_decode.sv ====
// Download stage: registered host stream, transfer classification,
// cartridge download edges, cheat table clear and console latch
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module dl_decode (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     ioctl_download_i,
	input  logic [7:0]               ioctl_index_i,
	input  logic                     ioctl_wr_i,
	input  logic [`MD_DL_ADDR_W-1:0] ioctl_addr_i,
	input  logic [`MD_DL_DATA_W-1:0] ioctl_data_i,
	output logic                     wr_o,
	output logic [`MD_DL_ADDR_W-1:0] addr_o,
	output logic [`MD_DL_DATA_W-1:0] data_o,
	output md_pkg::dl_kind_t         kind_o,
	output logic                     dl_start_o,
	output logic                     dl_end_o,
	output logic                     cheat_clear_o,
	output logic                     cart_ms_o,
	output md_pkg::region_t          ext_region_o
);

	logic             cart_dl;
	logic             cheat_dl;
	logic             cart_dl_q;
	md_pkg::dl_kind_t kind_d;

	// Index 1 is a Mega Drive image, 2 a Master System image, 0xFF a cheat file
	assign cart_dl  = ioctl_download_i &
		(ioctl_index_i[4:0] == 5'd1 || ioctl_index_i[4:0] == 5'd2);
	assign cheat_dl = ioctl_download_i & (&ioctl_index_i);

	always_comb begin
		if (cheat_dl) begin
			kind_d = md_pkg::DL_CHEAT;
		end else if (cart_dl && ioctl_index_i[4:0] == 5'd2) begin
			kind_d = md_pkg::DL_SMS_CART;
		end else if (cart_dl) begin
			kind_d = md_pkg::DL_MD_CART;
		end else begin
			kind_d = md_pkg::DL_NONE;
		end
	end

	////////////////////
	// Registered stream and pulses

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			wr_o          <= 1'b0;
			kind_o        <= md_pkg::DL_NONE;
			cart_dl_q     <= 1'b0;
			dl_start_o    <= 1'b0;
			dl_end_o      <= 1'b0;
			cheat_clear_o <= 1'b0;
			cart_ms_o     <= 1'b0;
		end else begin
			wr_o          <= ioctl_wr_i;
			kind_o        <= kind_d;
			cart_dl_q     <= cart_dl;
			dl_start_o    <= cart_dl & ~cart_dl_q;
			dl_end_o      <= ~cart_dl & cart_dl_q;
			// Fresh cartridge or a cheat file starting over at word 0
			cheat_clear_o <= (cart_dl & ~cart_dl_q) |
				(cheat_dl & ioctl_wr_i & (ioctl_addr_i == '0));
			// Console kind is held for the whole session
			if (cart_dl & ~cart_dl_q) begin
				cart_ms_o <= (ioctl_index_i[4:0] == 5'd2);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_o       <= ioctl_addr_i;
		data_o       <= ioctl_data_i;
		ext_region_o <= md_pkg::region_t'(ioctl_index_i[7:6]);
	end

endmodule

`default_nettype wire

// ==== hdr_region.sv ====
// Region stage: header scan for J/U/E codes and
// the region decision at the end of the header
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module hdr_region (
	input  logic                     clk_sys,
	input  logic                     sys_reset,
	input  logic                     wr_i,
	input  logic [`MD_DL_ADDR_W-1:0] addr_i,
	input  logic [`MD_DL_DATA_W-1:0] data_i,
	input  md_pkg::dl_kind_t         kind_i,
	input  logic                     dl_start_i,
	input  logic                     dl_end_i,
	input  md_pkg::region_t          ext_region_i,
	input  md_pkg::prio_t            prio_i,
	input  md_pkg::region_mode_t     mode_i,
	output md_pkg::region_t          region_o,
	output logic                     region_set_o
);

	localparam logic [`MD_DL_ADDR_W-1:0] HDR_ADDR0 = `MD_HDR_REGION_ADDR;
	localparam logic [`MD_DL_ADDR_W-1:0] HDR_ADDR1 = `MD_HDR_REGION2_ADDR;
	localparam logic [`MD_DL_ADDR_W-1:0] HDR_DONE  = `MD_HDR_DONE_ADDR;

	logic            flag_j;
	logic            flag_u;
	logic            flag_e;
	logic            hdr_wr;
	logic            hdr_done;
	logic [7:0]      lo_byte;
	logic [7:0]      hi_byte;
	logic [3:0]      hex_code;
	md_pkg::region_t hdr_pick;

	assign hdr_wr   = wr_i &
		(kind_i == md_pkg::DL_MD_CART || kind_i == md_pkg::DL_SMS_CART);
	assign hdr_done = wr_i & (kind_i == md_pkg::DL_MD_CART) & (addr_i == HDR_DONE);
	assign lo_byte  = data_i[7:0];
	assign hi_byte  = data_i[15:8];
	// Hex letters A..F come out as 10..15
	assign hex_code = data_i[3:0] - 4'd7;

	////////////////////
	// Header flags

	always_ff @(posedge clk_sys) begin
		if (sys_reset || dl_start_i) begin
			flag_j <= 1'b0;
			flag_u <= 1'b0;
			flag_e <= 1'b0;
		end else if (hdr_wr) begin
			if (addr_i == HDR_ADDR0) begin
				if (lo_byte == "J") begin
					flag_j <= 1'b1;
				end else if (lo_byte == "U") begin
					flag_u <= 1'b1;
				end else if (lo_byte == "E") begin
					flag_e <= 1'b1;
				end else if (lo_byte >= "0" && lo_byte <= "9") begin
					flag_e <= lo_byte[3];
					flag_u <= lo_byte[2];
					flag_j <= lo_byte[0];
				end else if (lo_byte >= "A" && lo_byte <= "F") begin
					flag_e <= hex_code[3];
					flag_u <= hex_code[2];
					flag_j <= hex_code[0];
				end
			end
			if (addr_i == HDR_ADDR1) begin
				if (lo_byte == "J") begin
					flag_j <= 1'b1;
				end else if (lo_byte == "U") begin
					flag_u <= 1'b1;
				end else if (lo_byte == "E") begin
					flag_e <= 1'b1;
				end
			end
			// High byte letters add to whatever the low byte gave
			if (addr_i == HDR_ADDR0) begin
				if (hi_byte == "J") begin
					flag_j <= 1'b1;
				end else if (hi_byte == "U") begin
					flag_u <= 1'b1;
				end else if (hi_byte == "E") begin
					flag_e <= 1'b1;
				end
			end
		end
	end

	// First flagged region in the order, else the order's head
	always_comb begin
		case (prio_i)
			md_pkg::PRIO_UEJ: hdr_pick = flag_u ? md_pkg::REGION_US :
				flag_e ? md_pkg::REGION_EU : flag_j ? md_pkg::REGION_JP : md_pkg::REGION_US;
			md_pkg::PRIO_EUJ: hdr_pick = flag_e ? md_pkg::REGION_EU :
				flag_u ? md_pkg::REGION_US : flag_j ? md_pkg::REGION_JP : md_pkg::REGION_EU;
			md_pkg::PRIO_UJE: hdr_pick = flag_u ? md_pkg::REGION_US :
				flag_j ? md_pkg::REGION_JP : flag_e ? md_pkg::REGION_EU : md_pkg::REGION_US;
			default: hdr_pick = flag_j ? md_pkg::REGION_JP :
				flag_u ? md_pkg::REGION_US : flag_e ? md_pkg::REGION_EU : md_pkg::REGION_JP;
		endcase
	end

	////////////////////
	// Region decision

	always_ff @(posedge clk_sys) begin
		if (sys_reset) begin
			region_o     <= md_pkg::REGION_JP;
			region_set_o <= 1'b0;
		end else begin
			if (dl_end_i) begin
				region_set_o <= 1'b0;
			end
			if (hdr_done) begin
				case (mode_i)
					md_pkg::MODE_HEADER: begin
						region_o     <= hdr_pick;
						region_set_o <= 1'b1;
					end
					md_pkg::MODE_FILE_EXT: begin
						// A cartridge index is never zero
						region_o     <= ext_region_i;
						region_set_o <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== md_cfg.svh ====
// Configuration macros for the cartridge download pipeline
// Header addresses, code layout, table depth and bus widths
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// Cartridge header word addresses
`define MD_HDR_REGION_ADDR  'h1F0
`define MD_HDR_REGION2_ADDR 'h1F2
`define MD_HDR_DONE_ADDR    'h200

// Host download stream
`define MD_DL_ADDR_W 25
`define MD_DL_DATA_W 16

// Cheat code table
`define MD_CHEAT_SLOTS 4
`define MD_CODE_WORDS  8

// CPU bus address widths
`define MD_M68K_ADDR_W 24
`define MD_Z80_ADDR_W  16

`endif

// ==== md_host_top.sv ====
// Top level of the cartridge download pipeline: download decode,
// header region, cheat loader and the two cheat engines
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module md_host_top (
	input  logic                       clk_sys,
	input  logic                       sys_reset,
	input  logic                       ioctl_download_i,
	input  logic [7:0]                 ioctl_index_i,
	input  logic                       ioctl_wr_i,
	input  logic [`MD_DL_ADDR_W-1:0]   ioctl_addr_i,
	input  logic [`MD_DL_DATA_W-1:0]   ioctl_data_i,
	input  md_pkg::prio_t              prio_i,
	input  md_pkg::region_mode_t       region_mode_i,
	input  logic                       cheats_on_i,
	input  logic [`MD_M68K_ADDR_W-1:0] m68k_addr_i,
	input  md_pkg::m68k_data_t         m68k_data_i,
	input  logic [`MD_Z80_ADDR_W-1:0]  z80_addr_i,
	input  md_pkg::z80_data_t          z80_data_i,
	output md_pkg::region_t            region_o,
	output logic                       region_set_o,
	output logic                       cart_ms_o,
	output logic                       cheats_avail_o,
	output md_pkg::m68k_data_t         m68k_data_o,
	output md_pkg::z80_data_t          z80_data_o
);

	logic                     dl_wr;
	logic [`MD_DL_ADDR_W-1:0] dl_addr;
	logic [`MD_DL_DATA_W-1:0] dl_data;
	md_pkg::dl_kind_t         dl_kind;
	logic                     dl_start;
	logic                     dl_end;
	logic                     cheat_clear;
	md_pkg::region_t          ext_region;
	md_pkg::cheat_code_t      code;
	logic                     code_valid;
	logic                     avail_m68k;
	logic                     avail_z80;

	assign cheats_avail_o = avail_m68k | avail_z80;

	dl_decode u_dl_decode (
		.clk_sys          (clk_sys),
		.sys_reset        (sys_reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.wr_o             (dl_wr),
		.addr_o           (dl_addr),
		.data_o           (dl_data),
		.kind_o           (dl_kind),
		.dl_start_o       (dl_start),
		.dl_end_o         (dl_end),
		.cheat_clear_o    (cheat_clear),
		.cart_ms_o        (cart_ms_o),
		.ext_region_o     (ext_region)
	);

	hdr_region u_hdr_region (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.wr_i         (dl_wr),
		.addr_i       (dl_addr),
		.data_i       (dl_data),
		.kind_i       (dl_kind),
		.dl_start_i   (dl_start),
		.dl_end_i     (dl_end),
		.ext_region_i (ext_region),
		.prio_i       (prio_i),
		.mode_i       (region_mode_i),
		.region_o     (region_o),
		.region_set_o (region_set_o)
	);

	cheat_loader u_cheat_loader (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.wr_i         (dl_wr),
		.addr_i       (dl_addr),
		.data_i       (dl_data),
		.kind_i       (dl_kind),
		.code_o       (code),
		.code_valid_o (code_valid)
	);

	////////////////////
	// One engine per CPU, chosen by the loaded console

	cheat_engine #(
		.data_t (md_pkg::m68k_data_t),
		.ADDR_W (`MD_M68K_ADDR_W)
	) u_cheat_m68k (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.clear_i      (cheat_clear),
		.code_i       (code),
		.code_valid_i (code_valid),
		.enable_i     (cheats_on_i & ~cart_ms_o),
		.bus_addr_i   (m68k_addr_i),
		.bus_data_i   (m68k_data_i),
		.bus_data_o   (m68k_data_o),
		.available_o  (avail_m68k)
	);

	cheat_engine #(
		.data_t (md_pkg::z80_data_t),
		.ADDR_W (`MD_Z80_ADDR_W)
	) u_cheat_z80 (
		.clk_sys      (clk_sys),
		.sys_reset    (sys_reset),
		.clear_i      (cheat_clear),
		.code_i       (code),
		.code_valid_i (code_valid),
		.enable_i     (cheats_on_i & cart_ms_o),
		.bus_addr_i   (z80_addr_i),
		.bus_data_i   (z80_data_i),
		.bus_data_o   (z80_data_o),
		.available_o  (avail_z80)
	);

endmodule

`default_nettype wire

// ==== md_pkg.sv ====
// Shared types: region, download kind, cheat code layout,
// priority order, region mode and CPU bus payloads
`default_nettype none

package md_pkg;

	// Same encoding as the host menu
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef enum logic [1:0] {
		DL_NONE,
		DL_MD_CART,
		DL_SMS_CART,
		DL_CHEAT
	} dl_kind_t;

	// flags[0] enables the compare value
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef enum logic [1:0] {
		PRIO_UEJ,
		PRIO_EUJ,
		PRIO_UJE,
		PRIO_JUE
	} prio_t;

	typedef enum logic [1:0] {
		MODE_HEADER,
		MODE_FILE_EXT,
		MODE_DISABLED
	} region_mode_t;

	typedef logic [15:0] m68k_data_t;
	typedef logic [7:0]  z80_data_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
verilator --binary -f verilog.f --top-module tb_md_host -o tb_md_host_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_md_host_sim > sim.log 2>&1
grep -q "Regression failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
	|| grep -q "Regression passed" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"

// ==== tb_checker.sv ====
// Testbench checker: compares region, console and bus outputs of the DUT
// against expected values on strobes from the stimulus side
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
	input  logic               clk_sys,
	input  logic               region_chk_i,
	input  md_pkg::region_t    exp_region_i,
	input  logic               exp_set_i,
	input  logic               bus_chk_i,
	input  md_pkg::m68k_data_t exp_m68k_i,
	input  md_pkg::z80_data_t  exp_z80_i,
	input  logic               exp_avail_i,
	input  logic               exp_ms_i,
	input  md_pkg::region_t    region_i,
	input  logic               region_set_i,
	input  logic               cart_ms_i,
	input  logic               cheats_avail_i,
	input  md_pkg::m68k_data_t m68k_data_i,
	input  md_pkg::z80_data_t  z80_data_i,
	output int                 error_count_o,
	output int                 check_count_o
);

	initial begin
		error_count_o = 0;
		check_count_o = 0;
	end

	////////////////////
	// Region decision

	always @(posedge clk_sys) begin
		if (region_chk_i) begin
			check_count_o = check_count_o + 1;
			if (region_set_i !== exp_set_i) begin
				$display("Fail at %0t: region_set %b, expected %b", $time, region_set_i, exp_set_i);
				error_count_o = error_count_o + 1;
			end else if (exp_set_i && region_i !== exp_region_i) begin
				$display("Fail at %0t: region %0d, expected %0d", $time, region_i, exp_region_i);
				error_count_o = error_count_o + 1;
			end
		end
	end

	////////////////////
	// Patched bus data

	always @(posedge clk_sys) begin
		if (bus_chk_i) begin
			check_count_o = check_count_o + 1;
			if (m68k_data_i !== exp_m68k_i) begin
				$display("Fail at %0t: m68k data %h, expected %h", $time, m68k_data_i, exp_m68k_i);
				error_count_o = error_count_o + 1;
			end
			if (z80_data_i !== exp_z80_i) begin
				$display("Fail at %0t: z80 data %h, expected %h", $time, z80_data_i, exp_z80_i);
				error_count_o = error_count_o + 1;
			end
			if (cheats_avail_i !== exp_avail_i) begin
				$display("Fail at %0t: cheats available %b, expected %b", $time,
					cheats_avail_i, exp_avail_i);
				error_count_o = error_count_o + 1;
			end
		end
	end

	////////////////////
	// Console kind latch

	always @(posedge clk_sys) begin
		if ((region_chk_i || bus_chk_i) && cart_ms_i !== exp_ms_i) begin
			$display("Fail at %0t: cart_ms %b, expected %b", $time, cart_ms_i, exp_ms_i);
			error_count_o = error_count_o + 1;
		end
	end

endmodule

`default_nettype wire

// ==== tb_md_host.sv ====
// Testbench top: clock, reset, row table of header and cheat cases,
// LFSR bus data and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "md_cfg.svh"

module tb_md_host;

	localparam int ROW_CYCLES = 64;

	typedef struct {
		bit          is_cheat;
		logic [7:0]  index;
		logic [15:0] hdr0;
		logic [15:0] hdr1;
		int          prio;
		int          mode;
		int          exp_region;
		logic        exp_set;
		logic        on;
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
		int          clear_mode;
	} row_t;

	logic clk_sys;
	logic sys_reset;
	logic ioctl_download_i;
	logic [7:0] ioctl_index_i;
	logic ioctl_wr_i;
	logic [`MD_DL_ADDR_W-1:0] ioctl_addr_i;
	logic [`MD_DL_DATA_W-1:0] ioctl_data_i;
	md_pkg::prio_t prio_i;
	md_pkg::region_mode_t region_mode_i;
	logic cheats_on_i;
	logic [`MD_M68K_ADDR_W-1:0] m68k_addr_i;
	md_pkg::m68k_data_t m68k_data_i;
	logic [`MD_Z80_ADDR_W-1:0] z80_addr_i;
	md_pkg::z80_data_t z80_data_i;
	md_pkg::region_t region_o;
	logic region_set_o;
	logic cart_ms_o;
	logic cheats_avail_o;
	md_pkg::m68k_data_t m68k_data_o;
	md_pkg::z80_data_t z80_data_o;

	logic region_chk;
	md_pkg::region_t exp_region;
	logic exp_set;
	logic bus_chk;
	md_pkg::m68k_data_t exp_m68k;
	md_pkg::z80_data_t exp_z80;
	logic exp_avail;
	logic exp_ms;
	int error_count;
	int check_count;

	row_t rows[$];
	bit rows_ready;
	logic [31:0] lfsr;

	md_host_top u_md_host_top (
		.clk_sys(clk_sys), .sys_reset(sys_reset),
		.ioctl_download_i(ioctl_download_i), .ioctl_index_i(ioctl_index_i),
		.ioctl_wr_i(ioctl_wr_i), .ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i),
		.prio_i(prio_i), .region_mode_i(region_mode_i), .cheats_on_i(cheats_on_i),
		.m68k_addr_i(m68k_addr_i), .m68k_data_i(m68k_data_i),
		.z80_addr_i(z80_addr_i), .z80_data_i(z80_data_i),
		.region_o(region_o), .region_set_o(region_set_o), .cart_ms_o(cart_ms_o),
		.cheats_avail_o(cheats_avail_o), .m68k_data_o(m68k_data_o), .z80_data_o(z80_data_o)
	);

	tb_checker u_tb_checker (
		.clk_sys(clk_sys), .region_chk_i(region_chk), .exp_region_i(exp_region),
		.exp_set_i(exp_set), .bus_chk_i(bus_chk), .exp_m68k_i(exp_m68k), .exp_z80_i(exp_z80),
		.exp_avail_i(exp_avail), .exp_ms_i(exp_ms), .region_i(region_o),
		.region_set_i(region_set_o), .cart_ms_i(cart_ms_o),
		.cheats_avail_i(cheats_avail_o), .m68k_data_i(m68k_data_o), .z80_data_i(z80_data_o),
		.error_count_o(error_count), .check_count_o(check_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Read data as the cheat rules say it should come back
	function automatic logic [15:0] expect_read(input logic en, input logic hit,
		input logic cmp_en, input logic [15:0] cmp, input logic [15:0] rep,
		input logic [15:0] data);
		if (en && hit && (!cmp_en || cmp == data)) begin
			return rep;
		end
		return data;
	endfunction

	task automatic add_hdr(input logic [7:0] index, input logic [15:0] hdr0,
		input logic [15:0] hdr1, input int prio, input int mode, input int exp_r,
		input logic set);
		row_t r;
		r = '{default: '0};
		r.index = index;
		r.hdr0 = hdr0;
		r.hdr1 = hdr1;
		r.prio = prio;
		r.mode = mode;
		r.exp_region = exp_r;
		r.exp_set = set;
		rows.push_back(r);
	endtask

	task automatic add_cheat(input logic [7:0] index, input logic on, input logic [31:0] flags,
		input logic [31:0] address, input logic [31:0] compare, input logic [31:0] replace,
		input int clear_mode);
		row_t r;
		r = '{default: '0};
		r.is_cheat = 1'b1;
		r.index = index;
		r.on = on;
		r.flags = flags;
		r.address = address;
		r.compare = compare;
		r.replace = replace;
		r.clear_mode = clear_mode;
		rows.push_back(r);
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_addr_i <= addr;
		ioctl_data_i <= data;
		ioctl_wr_i <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
	endtask

	task automatic cart_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index_i <= index;
		ioctl_download_i <= 1'b1;
		repeat (3) @(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_header(input row_t r);
		@(posedge clk_sys);
		prio_i <= md_pkg::prio_t'(r.prio);
		region_mode_i <= md_pkg::region_mode_t'(r.mode);
		cheats_on_i <= 1'b0;
		ioctl_index_i <= r.index;
		ioctl_download_i <= 1'b1;
		repeat (2) @(posedge clk_sys);
		write_word(25'h1F0, r.hdr0);
		write_word(25'h1F2, r.hdr1);
		// Nothing decided before the end of the header
		region_chk <= 1'b1;
		exp_set <= 1'b0;
		exp_ms <= (r.index[4:0] == 5'd2);
		@(posedge clk_sys);
		region_chk <= 1'b0;
		write_word(25'h200, 16'h0000);
		repeat (3) @(posedge clk_sys);
		region_chk <= 1'b1;
		exp_region <= md_pkg::region_t'(r.exp_region);
		exp_set <= r.exp_set;
		@(posedge clk_sys);
		region_chk <= 1'b0;
		ioctl_download_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic probe(input row_t r, input logic [23:0] addr, input logic [15:0] d16,
		input logic [7:0] d8, input logic loaded);
		logic ms;
		logic [15:0] ez;
		ms = (r.index[4:0] == 5'd2);
		ez = expect_read(r.on & ms, loaded && addr[15:0] == r.address[15:0], r.flags[0],
			{8'h00, r.compare[7:0]}, {8'h00, r.replace[7:0]}, {8'h00, d8});
		@(posedge clk_sys);
		m68k_addr_i <= addr;
		m68k_data_i <= d16;
		z80_addr_i <= addr[15:0];
		z80_data_i <= d8;
		@(posedge clk_sys);
		bus_chk <= 1'b1;
		exp_m68k <= expect_read(r.on & ~ms, loaded && addr == r.address[23:0], r.flags[0],
			r.compare[15:0], r.replace[15:0], d16);
		exp_z80 <= ez[7:0];
		exp_avail <= loaded;
		exp_ms <= ms;
		@(posedge clk_sys);
		bus_chk <= 1'b0;
	endtask

	task automatic run_cheat(input row_t r);
		logic [15:0] words [8];
		logic [31:0] v;
		logic [31:0] a;
		logic [15:0] c16;
		logic [7:0] c8;
		logic loaded;
		words = '{r.flags[15:0], r.flags[31:16], r.address[15:0], r.address[31:16],
			r.compare[15:0], r.compare[31:16], r.replace[15:0], r.replace[31:16]};
		loaded = (r.clear_mode == 0);
		cheats_on_i <= r.on;
		cart_download(r.index);
		@(posedge clk_sys);
		ioctl_index_i <= 8'hFF;
		ioctl_download_i <= 1'b1;
		for (int w = 0; w < 8; w++) begin
			write_word(25'(w * 2), words[w]);
		end
		ioctl_download_i <= 1'b0;
		repeat (4) @(posedge clk_sys);
		if (r.clear_mode == 1) begin
			cart_download(r.index);
		end else if (r.clear_mode == 2) begin
			ioctl_download_i <= 1'b1;
			write_word(25'h0, 16'h0000);
			ioctl_download_i <= 1'b0;
			repeat (3) @(posedge clk_sys);
		end
		rand_bits(16, v);
		c16 = r.flags[0] ? r.compare[15:0] : v[15:0];
		c8 = r.flags[0] ? r.compare[7:0] : v[7:0];
		probe(r, r.address[23:0], c16, c8, loaded);
		probe(r, r.address[23:0], c16 ^ 16'h1, c8 ^ 8'h1, loaded);
		// Other address always passes through
		rand_bits(24, a);
		rand_bits(16, v);
		probe(r, r.address[23:0] ^ {a[23:1], 1'b1}, v[15:0], v[7:0], loaded);
	endtask

	initial begin
		int first_region [4];
		first_region = '{1, 2, 1, 0};
		lfsr = 32'h219c;
		sys_reset = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		prio_i = md_pkg::PRIO_UEJ;
		region_mode_i = md_pkg::MODE_HEADER;
		cheats_on_i = 1'b0;
		m68k_addr_i = '0;
		m68k_data_i = '0;
		z80_addr_i = '0;
		z80_data_i = '0;
		region_chk = 1'b0;
		exp_region = md_pkg::REGION_JP;
		exp_set = 1'b0;
		bus_chk = 1'b0;
		exp_m68k = '0;
		exp_z80 = '0;
		exp_avail = 1'b0;
		exp_ms = 1'b0;

		// Single letters win in every order and no letters give the order's head
		for (int p = 0; p < 4; p++) begin
			add_hdr(8'h01, 16'h2055, 16'h2020, p, 0, 1, 1'b1);
			add_hdr(8'h01, 16'h4520, 16'h2020, p, 0, 2, 1'b1);
			add_hdr(8'h01, 16'h2020, 16'h204A, p, 0, 0, 1'b1);
			add_hdr(8'h01, 16'h2020, 16'h2020, p, 0, first_region[p], 1'b1);
		end
		// Digits and hex codes
		add_hdr(8'h01, 16'h2035, 16'h2020, 0, 0, 1, 1'b1);
		add_hdr(8'h01, 16'h2035, 16'h2020, 3, 0, 0, 1'b1);
		add_hdr(8'h01, 16'h2038, 16'h2020, 3, 0, 2, 1'b1);
		add_hdr(8'h01, 16'h2044, 16'h2020, 1, 0, 2, 1'b1);
		add_hdr(8'h01, 16'h2044, 16'h2020, 3, 0, 0, 1'b1);
		add_hdr(8'h01, 16'h2044, 16'h2020, 2, 0, 1, 1'b1);
		add_hdr(8'h01, 16'h2041, 16'h2020, 2, 0, 2, 1'b1);
		add_hdr(8'h01, 16'h4A34, 16'h2020, 0, 0, 1, 1'b1);
		add_hdr(8'h01, 16'h4A34, 16'h2020, 3, 0, 0, 1'b1);
		// File extension, disabled mode and Master System carts
		add_hdr(8'h41, 16'h2020, 16'h2020, 0, 1, 1, 1'b1);
		add_hdr(8'h81, 16'h2020, 16'h2020, 0, 1, 2, 1'b1);
		add_hdr(8'h01, 16'h2055, 16'h2020, 0, 1, 0, 1'b1);
		add_hdr(8'h01, 16'h2055, 16'h2020, 0, 2, 0, 1'b0);
		add_hdr(8'h02, 16'h2055, 16'h2020, 0, 0, 0, 1'b0);
		add_hdr(8'h42, 16'h2020, 16'h2020, 0, 1, 0, 1'b0);
		// Cheat engines
		add_cheat(8'h01, 1'b1, 32'h0, 32'h0001_2345, 32'h0, 32'h0000_BEEF, 0);
		add_cheat(8'h01, 1'b1, 32'h1, 32'h0000_FF10, 32'h1234, 32'h0000_5678, 0);
		add_cheat(8'h02, 1'b1, 32'h0, 32'h0000_C123, 32'h0, 32'h0000_00A5, 0);
		add_cheat(8'h02, 1'b1, 32'h1, 32'h0000_2000, 32'h3C, 32'h0000_0099, 0);
		add_cheat(8'h01, 1'b0, 32'h0, 32'h0000_0400, 32'h0, 32'h0000_1111, 0);
		add_cheat(8'h02, 1'b0, 32'h0, 32'h0000_0700, 32'h0, 32'h0000_0044, 0);
		add_cheat(8'h01, 1'b1, 32'h0, 32'h0000_0500, 32'h0, 32'h0000_2222, 1);
		add_cheat(8'h02, 1'b1, 32'h0, 32'h0000_0600, 32'h0, 32'h0000_0033, 2);
		rows_ready = 1'b1;

		repeat (10) @(posedge clk_sys);
		sys_reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		foreach (rows[i]) begin
			if (rows[i].is_cheat) begin
				run_cheat(rows[i]);
			end else begin
				run_header(rows[i]);
			end
		end
		repeat (4) @(posedge clk_sys);
		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog scaled to the row count
	initial begin
		wait (rows_ready);
		#((rows.size() * ROW_CYCLES + 200) * 8);
		$display("Timeout: the row table did not finish in time");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
md_pkg.sv
dl_decode.sv
hdr_region.sv
cheat_loader.sv
cheat_engine.sv
md_host_top.sv
tb_checker.sv
tb_md_host.sv
